// ==== logic/rv32i_cfg.svh ====
// build-time sizes for the execute/memory slice, included by files that need them
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// integer data path width
`define RV_XLEN 32

// pc shown by the EXE/MEM register out of reset
`define RV_RESET_PC 32'h40000000

// data memory depth in 32-bit words
// word index is the address above the byte offset, wrapping modulo the depth
`define RV_DMEM_WORDS 64

`endif

// ==== logic/rv32i_pkg.sv ====
// RV32I opcode and funct3 encodings plus the control word shared by the pipeline stages
`default_nettype none

package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add  = 3'b000, // add, sub by funct7
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101, // srl, sra by funct7
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3_e;

    typedef enum logic [2:0] {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } branch_funct3_e;

    // only the word and unsigned byte loads are built
    typedef enum logic [2:0] {f3_lw = 3'b010, f3_lbu = 3'b100} load_funct3_e;
    typedef enum logic [2:0] {f3_sb = 3'b000, f3_sw = 3'b010} store_funct3_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_RESET = '{opcode: op_lui, funct3: 3'b000, funct7: 7'b0};

endpackage

`default_nettype wire

// ==== logic/exe_mem_if.sv ====
// execute result bundle of one instruction, driven through src and read through dst
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

interface exe_mem_if;
    logic [`RV_XLEN-1:0]  result;     // alu value or branch/jump target
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  store_data;
    logic [`RV_XLEN-1:0]  u_imm;
    rv32i_pkg::ctrl_word_t ctrl;
    logic                 br_en;
    logic                 fresh;      // first cycle of a captured instruction

    modport src (
        output result, pc, store_data, u_imm,
        output ctrl, br_en, fresh
    );

    modport dst (
        input result, pc, store_data, u_imm,
        input ctrl, br_en, fresh
    );

endinterface

`default_nettype wire

// ==== logic/exe_stage.sv ====
// execute stage: ALU, branch compare and target adder filling the execute bundle
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module exe_stage (
    input  wire logic [`RV_XLEN-1:0] pc_i,
    input  wire logic [`RV_XLEN-1:0] rs1_i,
    input  wire logic [`RV_XLEN-1:0] rs2_i,
    input  wire logic [`RV_XLEN-1:0] imm_i,   // selected i/s/b/j immediate
    input  wire logic [`RV_XLEN-1:0] u_imm_i,
    input  wire rv32i_pkg::ctrl_word_t ctrl_i,
    exe_mem_if.src                   ex_o
);

    localparam int SHW = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] pc_imm;
    logic [`RV_XLEN-1:0] rs1_imm;
    logic [SHW-1:0]      shamt;
    logic                is_reg;
    logic                alt_op;
    logic                br_take;

    assign is_reg  = (ctrl_i.opcode == rv32i_pkg::op_reg);
    assign alu_b   = is_reg ? rs2_i : imm_i;
    assign shamt   = alu_b[SHW-1:0];
    assign alt_op  = ctrl_i.funct7[5];    // sub / sra select
    assign pc_imm  = pc_i + imm_i;        // branch and jal target
    assign rs1_imm = rs1_i + imm_i;       // jalr base and load/store address

    always_comb begin
        case (rv32i_pkg::arith_funct3_e'(ctrl_i.funct3))
            rv32i_pkg::f3_add:
                alu_out = (is_reg && alt_op) ? rs1_i - alu_b : rs1_i + alu_b;
            rv32i_pkg::f3_sll:  alu_out = rs1_i << shamt;
            rv32i_pkg::f3_slt:
                alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_i) < $signed(alu_b)};
            rv32i_pkg::f3_sltu: alu_out = {{(`RV_XLEN-1){1'b0}}, rs1_i < alu_b};
            rv32i_pkg::f3_xor:  alu_out = rs1_i ^ alu_b;
            rv32i_pkg::f3_sr: begin
                // srai has the same funct7 bit inside its immediate
                if (alt_op) begin
                    alu_out = $unsigned($signed(rs1_i) >>> shamt);
                end else begin
                    alu_out = rs1_i >> shamt;
                end
            end
            rv32i_pkg::f3_or:   alu_out = rs1_i | alu_b;
            rv32i_pkg::f3_and:  alu_out = rs1_i & alu_b;
            default:            alu_out = '0;
        endcase
    end

    // branch compare always on rs1/rs2
    always_comb begin
        case (rv32i_pkg::branch_funct3_e'(ctrl_i.funct3))
            rv32i_pkg::f3_beq:  br_take = (rs1_i == rs2_i);
            rv32i_pkg::f3_bne:  br_take = (rs1_i != rs2_i);
            rv32i_pkg::f3_blt:  br_take = ($signed(rs1_i) < $signed(rs2_i));
            rv32i_pkg::f3_bge:  br_take = ($signed(rs1_i) >= $signed(rs2_i));
            rv32i_pkg::f3_bltu: br_take = (rs1_i < rs2_i);
            rv32i_pkg::f3_bgeu: br_take = (rs1_i >= rs2_i);
            default:            br_take = 1'b0;
        endcase
    end

    always_comb begin
        ex_o.result = '0;
        ex_o.br_en  = 1'b0;
        case (ctrl_i.opcode)
            rv32i_pkg::op_imm,
            rv32i_pkg::op_reg:   ex_o.result = alu_out;
            rv32i_pkg::op_auipc: ex_o.result = pc_i + u_imm_i;
            rv32i_pkg::op_br: begin
                ex_o.result = pc_imm;
                ex_o.br_en  = br_take;
            end
            rv32i_pkg::op_jal: begin
                ex_o.result = pc_imm;
                ex_o.br_en  = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                ex_o.result = {rs1_imm[`RV_XLEN-1:1], 1'b0};
                ex_o.br_en  = 1'b1;
            end
            rv32i_pkg::op_load,
            rv32i_pkg::op_store: ex_o.result = rs1_imm;
            default:             ex_o.result = '0;   // lui uses u_imm downstream
        endcase
    end

    // pass-through fields
    assign ex_o.pc         = pc_i;
    assign ex_o.store_data = rs2_i;
    assign ex_o.u_imm      = u_imm_i;
    assign ex_o.ctrl       = ctrl_i;
    assign ex_o.fresh      = 1'b0;   // only meaningful after the pipeline register

endmodule

`default_nettype wire

// ==== logic/exe_mem_reg.sv ====
// EXE/MEM pipeline register, loads on the go strobe and keeps its outputs through hold
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module exe_mem_reg (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic go_i,     // load strobe from the controller
    input  wire logic hold_i,   // keep outputs, still report ready
    exe_mem_if.dst    ex_i,
    exe_mem_if.src    mem_o,
    output logic      exe_rdy_o
);

    // shadow copies of the captured bundle
    logic [`RV_XLEN-1:0]   result_r;
    logic [`RV_XLEN-1:0]   pc_r;
    logic [`RV_XLEN-1:0]   store_data_r;
    logic [`RV_XLEN-1:0]   u_imm_r;
    rv32i_pkg::ctrl_word_t ctrl_r;
    logic                  br_en_r;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            result_r     <= '0;
            pc_r         <= `RV_RESET_PC;
            store_data_r <= '0;
            u_imm_r      <= '0;
            ctrl_r       <= rv32i_pkg::CTRL_RESET;
            br_en_r      <= 1'b0;
        end else if (go_i) begin
            result_r     <= ex_i.result;
            pc_r         <= ex_i.pc;
            store_data_r <= ex_i.store_data;
            u_imm_r      <= ex_i.u_imm;
            ctrl_r       <= ex_i.ctrl;
            br_en_r      <= ex_i.br_en;
        end
    end

    // output registers take the new value on go and otherwise reload from the shadow
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mem_o.result     <= '0;
            mem_o.pc         <= `RV_RESET_PC;
            mem_o.store_data <= '0;
            mem_o.u_imm      <= '0;
            mem_o.ctrl       <= rv32i_pkg::CTRL_RESET;
            mem_o.br_en      <= 1'b0;
        end else if (go_i) begin
            mem_o.result     <= ex_i.result;
            mem_o.pc         <= ex_i.pc;
            mem_o.store_data <= ex_i.store_data;
            mem_o.u_imm      <= ex_i.u_imm;
            mem_o.ctrl       <= ex_i.ctrl;
            mem_o.br_en      <= ex_i.br_en;
        end else begin
            mem_o.result     <= result_r;
            mem_o.pc         <= pc_r;
            mem_o.store_data <= store_data_r;
            mem_o.u_imm      <= u_imm_r;
            mem_o.ctrl       <= ctrl_r;
            mem_o.br_en      <= br_en_r;
        end
    end

    // fresh for one cycle per capture, ready from go or hold
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mem_o.fresh <= 1'b0;
            exe_rdy_o   <= 1'b0;
        end else begin
            mem_o.fresh <= go_i;
            exe_rdy_o   <= go_i | hold_i;   // hold alone keeps ready high
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
// memory stage: word-addressed data memory for lw/lbu/sw/sb and the writeback select
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module mem_stage (
    input  wire logic            clk,
    input  wire logic            rst,
    exe_mem_if.dst               mem_i,
    output logic [`RV_XLEN-1:0]  wb_data_o,
    output logic [`RV_XLEN-1:0]  br_target_o,
    output logic                 wb_en_o,
    output logic                 br_en_o
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]    word_idx;
    logic [1:0]          byte_off;
    logic [`RV_XLEN-1:0] rd_word;
    logic [7:0]          rd_byte;
    logic                st_fire;

    // address bits above the offset, wraps modulo the depth
    assign word_idx = mem_i.result[IDX_W+1:2];
    assign byte_off = mem_i.result[1:0];
    assign rd_word  = dmem[word_idx];                    // async read
    assign rd_byte  = rd_word[{byte_off, 3'b000} +: 8];

    // a store writes once, at the end of its fresh cycle
    assign st_fire = mem_i.fresh && (mem_i.ctrl.opcode == rv32i_pkg::op_store);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_fire) begin
            case (rv32i_pkg::store_funct3_e'(mem_i.ctrl.funct3))
                rv32i_pkg::f3_sw: dmem[word_idx] <= mem_i.store_data;
                rv32i_pkg::f3_sb: begin
                    // byte lane from address bits 1:0
                    dmem[word_idx][{byte_off, 3'b000} +: 8] <= mem_i.store_data[7:0];
                end
                default: ;   // halfword stores not built
            endcase
        end
    end

    // writeback value per opcode
    always_comb begin
        wb_data_o = '0;
        wb_en_o   = 1'b0;
        case (mem_i.ctrl.opcode)
            rv32i_pkg::op_lui: begin
                wb_data_o = mem_i.u_imm;
                wb_en_o   = 1'b1;
            end
            rv32i_pkg::op_auipc,
            rv32i_pkg::op_imm,
            rv32i_pkg::op_reg: begin
                wb_data_o = mem_i.result;
                wb_en_o   = 1'b1;
            end
            rv32i_pkg::op_jal,
            rv32i_pkg::op_jalr: begin
                wb_data_o = mem_i.pc + `RV_XLEN'd4;   // link address
                wb_en_o   = 1'b1;
            end
            rv32i_pkg::op_load: begin
                wb_en_o = 1'b1;
                if (rv32i_pkg::load_funct3_e'(mem_i.ctrl.funct3) == rv32i_pkg::f3_lbu) begin
                    wb_data_o = {{(`RV_XLEN-8){1'b0}}, rd_byte};
                end else begin
                    wb_data_o = rd_word;
                end
            end
            default: begin
                // br and store write nothing back
                wb_data_o = '0;
                wb_en_o   = 1'b0;
            end
        endcase
    end

    assign br_target_o = mem_i.result;
    assign br_en_o     = mem_i.br_en;

endmodule

`default_nettype wire

// ==== logic/exe_mem_top.sv ====
// top of the execute-to-memory slice, plain ports toward decode, controller and writeback
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module exe_mem_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                go_i,
    input  wire logic                hold_i,
    input  wire logic [`RV_XLEN-1:0] pc_i,
    input  wire logic [`RV_XLEN-1:0] rs1_i,
    input  wire logic [`RV_XLEN-1:0] rs2_i,
    input  wire logic [`RV_XLEN-1:0] imm_i,
    input  wire logic [`RV_XLEN-1:0] u_imm_i,
    input  wire rv32i_pkg::opcode_e  opcode_i,
    input  wire logic [2:0]          funct3_i,
    input  wire logic [6:0]          funct7_i,
    output wire logic                exe_rdy_o,
    output wire logic [`RV_XLEN-1:0] wb_data_o,
    output wire logic                wb_en_o,
    output wire logic                br_en_o,
    output wire logic [`RV_XLEN-1:0] br_target_o
);

    exe_mem_if ex_bus ();    // combinational execute results
    exe_mem_if mem_bus ();   // registered copy for the memory stage

    exe_stage i_exe_stage (
        .pc_i    (pc_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .imm_i   (imm_i),
        .u_imm_i (u_imm_i),
        .ctrl_i  ({opcode_i, funct3_i, funct7_i}),
        .ex_o    (ex_bus.src)
    );

    exe_mem_reg i_exe_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .go_i      (go_i),
        .hold_i    (hold_i),
        .ex_i      (ex_bus.dst),
        .mem_o     (mem_bus.src),
        .exe_rdy_o (exe_rdy_o)
    );

    mem_stage i_mem_stage (
        .clk         (clk),
        .rst         (rst),
        .mem_i       (mem_bus.dst),
        .wb_data_o   (wb_data_o),
        .br_target_o (br_target_o),
        .wb_en_o     (wb_en_o),
        .br_en_o     (br_en_o)
    );

endmodule

`default_nettype wire

// ==== bench/exe_mem_tb.sv ====
// self-checking testbench for exe_mem_top, random instructions checked against a model
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_cfg.svh"

module exe_mem_tb;

    localparam int CLK_HALF = 4;
    localparam int CYCLES   = 4000;
    localparam int LIMIT_NS = (CYCLES + 50) * 2 * CLK_HALF;   // stimulus plus margin

    logic                clk;
    logic                rst;
    logic                go_i;
    logic                hold_i;
    logic [`RV_XLEN-1:0] pc_i;
    logic [`RV_XLEN-1:0] rs1_i;
    logic [`RV_XLEN-1:0] rs2_i;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] u_imm_i;
    rv32i_pkg::opcode_e  opcode_i;
    logic [2:0]          funct3_i;
    logic [6:0]          funct7_i;
    logic                exe_rdy_o;
    logic [`RV_XLEN-1:0] wb_data_o;
    logic                wb_en_o;
    logic                br_en_o;
    logic [`RV_XLEN-1:0] br_target_o;

    // values applied to the DUT for the coming edge
    logic               drv_go;
    logic               drv_hold;
    logic [31:0]        drv_pc;
    logic [31:0]        drv_rs1;
    logic [31:0]        drv_rs2;
    logic [31:0]        drv_imm;
    logic [31:0]        drv_uimm;
    rv32i_pkg::opcode_e drv_op;
    logic [2:0]         drv_f3;
    logic [6:0]         drv_f7;

    // model state
    logic        ready_m;
    logic [31:0] exp_wb;
    logic        exp_wb_en;
    logic        exp_br_en;
    logic [31:0] exp_tgt;
    logic        tgt_known;    // lui leaves result undefined
    logic        held_cyc;     // go was low at the last edge
    logic        pend_st;
    logic        pend_byte;
    int          pend_idx;
    logic [1:0]  pend_off;
    logic [31:0] pend_data;
    logic [31:0] mem_m [`RV_DMEM_WORDS];
    logic [31:0] last_wb;
    logic        last_wb_en;
    logic        last_br_en;
    logic [31:0] last_tgt;

    exe_mem_top i_exe_mem_top (
        .clk         (clk),
        .rst         (rst),
        .go_i        (go_i),
        .hold_i      (hold_i),
        .pc_i        (pc_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .u_imm_i     (u_imm_i),
        .opcode_i    (opcode_i),
        .funct3_i    (funct3_i),
        .funct7_i    (funct7_i),
        .exe_rdy_o   (exe_rdy_o),
        .wb_data_o   (wb_data_o),
        .wb_en_o     (wb_en_o),
        .br_en_o     (br_en_o),
        .br_target_o (br_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_run(string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            fail_run("output mismatch against the model");
        end
    endtask

    function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                               logic [31:0] b);
        case (f3)
            rv32i_pkg::f3_add:  return alt ? a - b : a + b;
            rv32i_pkg::f3_sll:  return a << b[4:0];
            rv32i_pkg::f3_slt:  return {31'b0, $signed(a) < $signed(b)};
            rv32i_pkg::f3_sltu: return {31'b0, a < b};
            rv32i_pkg::f3_xor:  return a ^ b;
            rv32i_pkg::f3_sr:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            rv32i_pkg::f3_or:   return a | b;
            default:            return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            rv32i_pkg::f3_beq:  return a == b;
            rv32i_pkg::f3_bne:  return a != b;
            rv32i_pkg::f3_blt:  return $signed(a) < $signed(b);
            rv32i_pkg::f3_bge:  return $signed(a) >= $signed(b);
            rv32i_pkg::f3_bltu: return a < b;
            default:            return a >= b;   // bgeu
        endcase
    endfunction

    // model update at a rising edge from the inputs the DUT samples there
    task automatic model_edge();
        logic [31:0] addr;
        logic        alt;
        int          widx;
        if (pend_st) begin
            // store leaves its fresh cycle here
            if (pend_byte) begin
                mem_m[pend_idx][{pend_off, 3'b000} +: 8] = pend_data[7:0];
            end else begin
                mem_m[pend_idx] = pend_data;
            end
            pend_st = 1'b0;
        end
        ready_m  = drv_go | drv_hold;
        held_cyc = !drv_go;
        if (drv_go) begin
            addr      = drv_rs1 + drv_imm;
            widx      = int'(addr[31:2]) % `RV_DMEM_WORDS;
            alt       = drv_f7[5] && (drv_op == rv32i_pkg::op_reg || drv_f3 == rv32i_pkg::f3_sr);
            exp_wb    = '0;
            exp_wb_en = 1'b0;
            exp_br_en = 1'b0;
            exp_tgt   = addr;   // load/store address
            tgt_known = 1'b1;
            case (drv_op)
                rv32i_pkg::op_lui: begin
                    exp_wb    = drv_uimm;
                    exp_wb_en = 1'b1;
                    tgt_known = 1'b0;
                end
                rv32i_pkg::op_auipc: begin
                    exp_tgt   = drv_pc + drv_uimm;
                    exp_wb    = exp_tgt;
                    exp_wb_en = 1'b1;
                end
                rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                    exp_tgt   = alu_result(drv_f3, alt, drv_rs1,
                                           (drv_op == rv32i_pkg::op_reg) ? drv_rs2 : drv_imm);
                    exp_wb    = exp_tgt;
                    exp_wb_en = 1'b1;
                end
                rv32i_pkg::op_jal, rv32i_pkg::op_jalr: begin
                    exp_tgt   = (drv_op == rv32i_pkg::op_jal) ? drv_pc + drv_imm : addr & ~32'h1;
                    exp_br_en = 1'b1;
                    exp_wb    = drv_pc + 32'd4;   // link
                    exp_wb_en = 1'b1;
                end
                rv32i_pkg::op_br: begin
                    exp_tgt   = drv_pc + drv_imm;
                    exp_br_en = branch_taken(drv_f3, drv_rs1, drv_rs2);
                end
                rv32i_pkg::op_load: begin
                    exp_wb_en = 1'b1;
                    if (drv_f3 == rv32i_pkg::f3_lbu) begin
                        exp_wb = {24'b0, mem_m[widx][{addr[1:0], 3'b000} +: 8]};
                    end else begin
                        exp_wb = mem_m[widx];
                    end
                end
                rv32i_pkg::op_store: begin
                    pend_st   = 1'b1;
                    pend_byte = (drv_f3 == rv32i_pkg::f3_sb);
                    pend_idx  = widx;
                    pend_off  = addr[1:0];
                    pend_data = drv_rs2;
                end
                default: ;
            endcase
        end
    endtask

    task automatic draw_stimulus();
        logic [31:0] r;
        logic [31:0] s;
        int          widx;
        int          off;
        r        = $urandom();
        s        = $urandom();
        drv_go   = r[0];
        drv_hold = r[1] & r[2];
        drv_pc   = $urandom() & 32'hffff_fffc;
        drv_rs1  = $urandom();
        drv_rs2  = (r[4:3] == 2'b00) ? drv_rs1 : $urandom();   // equal operands now and then
        drv_uimm = $urandom() & 32'hffff_f000;
        drv_imm  = {{20{s[11]}}, s[11:0]};
        drv_f3   = r[7:5];
        drv_f7   = s[31:25];
        case ($urandom_range(0, 10))
            0: drv_op = rv32i_pkg::op_lui;
            1: drv_op = rv32i_pkg::op_auipc;
            2: begin
                drv_op  = rv32i_pkg::op_jal;
                drv_imm = {{11{s[20]}}, s[20:1], 1'b0};
            end
            3: begin
                drv_op = rv32i_pkg::op_jalr;
                drv_f3 = 3'b000;
            end
            4: begin
                drv_op  = rv32i_pkg::op_br;
                drv_imm = {{19{s[12]}}, s[12:1], 1'b0};
                if (drv_f3 == 3'b010 || drv_f3 == 3'b011) begin
                    drv_f3 = drv_f3 + 3'd4;   // no branch at 2 and 3
                end
            end
            5, 6, 7, 8: begin
                // mostly a narrow window of words so stores and loads overlap
                if (r[9:8] == 2'b00) begin
                    widx = $urandom_range(0, `RV_DMEM_WORDS - 1);
                end else begin
                    widx = $urandom_range(0, 7);
                end
                if (r[10]) begin
                    drv_op = rv32i_pkg::op_load;
                    drv_f3 = r[11] ? rv32i_pkg::f3_lw : rv32i_pkg::f3_lbu;
                end else begin
                    drv_op = rv32i_pkg::op_store;
                    drv_f3 = r[11] ? rv32i_pkg::f3_sw : rv32i_pkg::f3_sb;
                end
                off     = (drv_f3 == rv32i_pkg::f3_lbu || drv_f3 == rv32i_pkg::f3_sb) ?
                          int'(r[13:12]) : 0;
                drv_rs1 = 32'(widx * 4 + off) - drv_imm;   // rs1 + imm hits the chosen byte
            end
            9: begin
                drv_op = rv32i_pkg::op_imm;
                if (drv_f3 == rv32i_pkg::f3_sll || drv_f3 == rv32i_pkg::f3_sr) begin
                    drv_imm = {20'b0, (drv_f3 == rv32i_pkg::f3_sr && r[12]) ? 7'h20 : 7'h00,
                               s[4:0]};
                end
                drv_f7 = drv_imm[11:5];   // funct7 field sits in the immediate
            end
            default: begin
                drv_op = rv32i_pkg::op_reg;
                drv_f7 = (r[12] && (drv_f3 == rv32i_pkg::f3_add || drv_f3 == rv32i_pkg::f3_sr)) ?
                         7'h20 : 7'h00;
            end
        endcase
    endtask

    task automatic drive_inputs();
        go_i     <= drv_go;
        hold_i   <= drv_hold;
        pc_i     <= drv_pc;
        rs1_i    <= drv_rs1;
        rs2_i    <= drv_rs2;
        imm_i    <= drv_imm;
        u_imm_i  <= drv_uimm;
        opcode_i <= drv_op;
        funct3_i <= drv_f3;
        funct7_i <= drv_f7;
    endtask

    task automatic check_outputs();
        check_equal("exe_rdy_o", 32'(ready_m), 32'(exe_rdy_o));
        check_equal("wb_data_o", exp_wb, wb_data_o);
        check_equal("wb_en_o", 32'(exp_wb_en), 32'(wb_en_o));
        check_equal("br_en_o", 32'(exp_br_en), 32'(br_en_o));
        if (tgt_known) begin
            check_equal("br_target_o", exp_tgt, br_target_o);
        end
        if (held_cyc) begin
            // frozen while go stays low
            check_equal("wb_data_o (held)", last_wb, wb_data_o);
            check_equal("wb_en_o (held)", 32'(last_wb_en), 32'(wb_en_o));
            check_equal("br_en_o (held)", 32'(last_br_en), 32'(br_en_o));
            check_equal("br_target_o (held)", last_tgt, br_target_o);
        end
        last_wb    = wb_data_o;
        last_wb_en = wb_en_o;
        last_br_en = br_en_o;
        last_tgt   = br_target_o;
    endtask

    initial begin
        void'($urandom(32'h475));
        rst      = 1'b1;
        drv_go   = 1'b0;
        drv_hold = 1'b0;
        drv_pc   = '0;
        drv_rs1  = '0;
        drv_rs2  = '0;
        drv_imm  = '0;
        drv_uimm = '0;
        drv_op   = rv32i_pkg::op_lui;
        drv_f3   = 3'b000;
        drv_f7   = 7'b0;
        drive_inputs();
        // reset view is lui with zero u_imm
        ready_m     = 1'b0;
        exp_wb      = '0;
        exp_wb_en   = 1'b1;
        exp_br_en   = 1'b0;
        exp_tgt     = '0;
        tgt_known   = 1'b1;
        held_cyc    = 1'b0;
        pend_st     = 1'b0;
        pend_byte   = 1'b0;
        pend_idx    = 0;
        pend_off    = 2'b00;
        pend_data   = '0;
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            mem_m[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs();
        for (int cyc = 0; cyc < CYCLES; cyc++) begin
            @(posedge clk);
            model_edge();
            draw_stimulus();
            drive_inputs();
            @(negedge clk);   // outputs settled
            check_outputs();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #LIMIT_NS;
        $display("timeout: the stimulus did not finish within %0d ns", LIMIT_NS);
        fail_run("run stopped by the watchdog");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/rv32i_pkg.sv
logic/exe_mem_if.sv
logic/exe_stage.sv
logic/exe_mem_reg.sv
logic/mem_stage.sv
logic/exe_mem_top.sv
bench/exe_mem_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute/memory slice testbench

TOP := exe_mem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -j 0 -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
